//--- flist.f
src/fetch_pkg.sv
src/instruction_memory.sv
src/fetch_unit.sv
src/debug_control.sv
src/fetch_top.sv
tests/fetch_assertions.sv
tests/fetch_tb.sv

//--- run.sh
#!/bin/sh
# Build the fetch testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
  --top-module fetch_tb -Mdir "$BUILD_DIR" -f flist.f
status=$?
if [ "$status" -ne 0 ]; then
  echo "compile failed with status $status"
  exit 1
fi

"./$BUILD_DIR/Vfetch_tb" > "$LOG" 2>&1
run_status=$?
cat "$LOG"

if grep -q "SOME TESTS FAILED" "$LOG"; then
  echo "simulation reported failure"
  exit 1
fi
if [ "$run_status" -ne 0 ]; then
  echo "simulation exited with status $run_status"
  exit 1
fi
echo "simulation passed"
exit 0

//--- src/debug_control.sv
`timescale 1ns/1ps

module debug_control #(
  parameter int unsigned MEM_DEPTH = 256  // Bytes a load may write
) (
  input  logic                          i_clock,
  input  logic                          i_rst_n,
  input  logic                          i_cmd_valid,     // Host command strobe
  input  fetch_pkg::dbg_cmd_e           i_cmd,
  input  logic                          i_byte_valid,    // Host byte strobe
  input  logic [fetch_pkg::NB_BYTE-1:0] i_byte,
  input  logic                          i_halt,          // From fetch stage
  output logic                          o_write_enable,
  output logic [fetch_pkg::NB_ADDR-1:0] o_write_addr,
  output logic [fetch_pkg::NB_BYTE-1:0] o_write_data,
  output logic                          o_run,           // Level, high in ST_RUN
  output logic                          o_step,          // One fetch request
  output logic                          o_pc_clear,      // Restart fetch at address 0
  output fetch_pkg::dbg_state_e         o_state
);

  localparam logic [fetch_pkg::NB_ADDR-1:0] PTR_LAST = MEM_DEPTH - 1;  // Final byte slot

  fetch_pkg::dbg_state_e state_q;
  fetch_pkg::dbg_state_e state_d;
  logic [fetch_pkg::NB_ADDR-1:0]   wr_ptr_q;     // Next byte address during a load
  logic [3*fetch_pkg::NB_BYTE-1:0] byte_hist_q;  // Three bytes before the current one
  logic cmd_load;
  logic cmd_run;
  logic cmd_step;
  logic load_start;   // CMD_LOAD accepted
  logic load_byte;    // Byte goes to memory this cycle
  logic halt_word;    // Current byte closes an aligned halt word
  logic last_byte;    // Current byte fills the memory
  logic step_d;
  logic clear_d;

  // Command decode, NOP and invalid cycles do nothing
  always_comb begin
    cmd_load = 1'b0;
    cmd_run  = 1'b0;
    cmd_step = 1'b0;
    if (i_cmd_valid) begin
      case (i_cmd)
        fetch_pkg::CMD_LOAD: cmd_load = 1'b1;
        fetch_pkg::CMD_RUN:  cmd_run  = 1'b1;
        fetch_pkg::CMD_STEP: cmd_step = 1'b1;
        fetch_pkg::CMD_NOP:  ;
        default:             ;
      endcase
    end
  end

  assign load_start = cmd_load && (state_q != fetch_pkg::ST_LOAD);  // Ignored mid-load
  assign load_byte  = i_byte_valid && (state_q == fetch_pkg::ST_LOAD);

  // Write port is combinational, byte lands on this clock edge
  assign o_write_enable = load_byte;
  assign o_write_addr   = wr_ptr_q;
  assign o_write_data   = i_byte;

  // Word at ptr-3 is aligned when the low pointer bits are 3
  assign halt_word = (wr_ptr_q[1:0] == 2'b11) &&
                     ({byte_hist_q, i_byte} == fetch_pkg::HALT_INSTR);
  assign last_byte = (wr_ptr_q == PTR_LAST);

  always_comb begin
    state_d = state_q;
    step_d  = 1'b0;
    clear_d = 1'b0;
    case (state_q)
      fetch_pkg::ST_IDLE, fetch_pkg::ST_HALTED: begin
        if (cmd_load) begin
          state_d = fetch_pkg::ST_LOAD;
          clear_d = 1'b1;
        end else if (cmd_run) begin
          state_d = fetch_pkg::ST_RUN;
          clear_d = 1'b1;
        end else if (cmd_step) begin
          state_d = fetch_pkg::ST_STEP;  // No fetch on entry
          clear_d = 1'b1;
        end
      end
      fetch_pkg::ST_LOAD: begin
        if (load_byte && (halt_word || last_byte)) begin
          state_d = fetch_pkg::ST_IDLE;
        end
      end
      fetch_pkg::ST_RUN: begin
        if (cmd_load) begin
          state_d = fetch_pkg::ST_LOAD;
          clear_d = 1'b1;  // Drops the read still in flight
        end else if (i_halt) begin
          state_d = fetch_pkg::ST_HALTED;
        end
      end
      fetch_pkg::ST_STEP: begin
        if (cmd_load) begin
          state_d = fetch_pkg::ST_LOAD;
          clear_d = 1'b1;
        end else if (i_halt) begin
          state_d = fetch_pkg::ST_HALTED;  // A step in the same cycle is lost
        end else if (cmd_step) begin
          step_d = 1'b1;
        end
      end
      default: state_d = fetch_pkg::ST_IDLE;
    endcase
  end

  always_ff @(posedge i_clock) begin
    if (!i_rst_n) begin
      state_q    <= fetch_pkg::ST_IDLE;
      wr_ptr_q   <= '0;
      o_step     <= 1'b0;
      o_pc_clear <= 1'b0;
    end else begin
      state_q    <= state_d;
      o_step     <= step_d;   // Step reaches fetch one cycle after the command
      o_pc_clear <= clear_d;
      if (load_start) begin
        wr_ptr_q <= '0;
      end else if (load_byte) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
    end
  end

  // Only bytes of the current load are compared, stale history never matters
  always_ff @(posedge i_clock) begin
    if (load_byte) begin
      byte_hist_q <= {byte_hist_q[2*fetch_pkg::NB_BYTE-1:0], i_byte};
    end
  end

  assign o_run   = (state_q == fetch_pkg::ST_RUN);
  assign o_state = state_q;

endmodule

//--- src/fetch_pkg.sv
package fetch_pkg;

  // Bus widths shared by the fetch datapath and the debug loader
  localparam int NB_ADDR        = 32;  // Byte address
  localparam int NB_INSTRUCTION = 32;  // One instruction word
  localparam int NB_BYTE        = 8;   // One memory entry

  // All ones word stops the fetch stage and also ends a program load
  localparam logic [NB_INSTRUCTION-1:0] HALT_INSTR = 32'hFFFF_FFFF;

  // Host commands, one per i_cmd_valid strobe
  typedef enum logic [1:0] {
    CMD_LOAD = 2'b00,  // Start a byte load at address 0
    CMD_RUN  = 2'b01,  // Free running fetch from address 0
    CMD_STEP = 2'b10,  // Enter step mode, or fetch one word when already there
    CMD_NOP  = 2'b11   // Nothing to do
  } dbg_cmd_e;

  // Debug controller states
  typedef enum logic [2:0] {
    ST_IDLE   = 3'd0,
    ST_LOAD   = 3'd1,  // Byte stream goes into instruction memory
    ST_RUN    = 3'd2,
    ST_STEP   = 3'd3,  // One fetch per host step command
    ST_HALTED = 3'd4   // Halt word was fetched
  } dbg_state_e;

  // One fetched instruction together with the address it came from
  typedef struct packed {
    logic [NB_ADDR-1:0]        pc;     // Address of the first byte
    logic [NB_INSTRUCTION-1:0] instr;  // Big-endian word read there
  } fetch_out_t;

endpackage

//--- src/fetch_top.sv
`timescale 1ns/1ps

module fetch_top #(
  parameter int unsigned MEM_DEPTH = 256  // Instruction memory bytes
) (
  input  logic                          i_clock,
  input  logic                          i_rst_n,
  input  logic                          i_cmd_valid,
  input  fetch_pkg::dbg_cmd_e           i_cmd,
  input  logic                          i_byte_valid,
  input  logic [fetch_pkg::NB_BYTE-1:0] i_byte,
  input  logic                          i_branch_valid,
  input  logic [fetch_pkg::NB_ADDR-1:0] i_branch_target,
  output logic                          o_fetch_valid,
  output fetch_pkg::fetch_out_t         o_fetch,
  output fetch_pkg::dbg_state_e         o_state
);

  // Loader write port
  logic                                 mem_write_enable;
  logic [fetch_pkg::NB_ADDR-1:0]        mem_write_addr;
  logic [fetch_pkg::NB_BYTE-1:0]        mem_write_data;
  // Fetch read port
  logic                                 mem_read_enable;
  logic [fetch_pkg::NB_ADDR-1:0]        mem_read_addr;
  logic [fetch_pkg::NB_INSTRUCTION-1:0] mem_read_data;
  // Debug to fetch control
  logic run;
  logic step;
  logic pc_clear;
  logic halt;

  instruction_memory #(.MEM_DEPTH(MEM_DEPTH)) u_instruction_memory (
    .i_clock        (i_clock),
    .i_write_enable (mem_write_enable),
    .i_write_addr   (mem_write_addr),
    .i_write_data   (mem_write_data),
    .i_read_enable  (mem_read_enable),
    .i_read_addr    (mem_read_addr),
    .o_read_data    (mem_read_data)
  );

  fetch_unit #(.MEM_DEPTH(MEM_DEPTH)) u_fetch_unit (
    .i_clock         (i_clock),
    .i_rst_n         (i_rst_n),
    .i_run           (run),
    .i_step          (step),
    .i_pc_clear      (pc_clear),
    .i_branch_valid  (i_branch_valid),
    .i_branch_target (i_branch_target),
    .i_read_data     (mem_read_data),
    .o_read_enable   (mem_read_enable),
    .o_read_addr     (mem_read_addr),
    .o_fetch_valid   (o_fetch_valid),
    .o_fetch         (o_fetch),
    .o_halt          (halt)
  );

  debug_control #(.MEM_DEPTH(MEM_DEPTH)) u_debug_control (
    .i_clock        (i_clock),
    .i_rst_n        (i_rst_n),
    .i_cmd_valid    (i_cmd_valid),
    .i_cmd          (i_cmd),
    .i_byte_valid   (i_byte_valid),
    .i_byte         (i_byte),
    .i_halt         (halt),
    .o_write_enable (mem_write_enable),
    .o_write_addr   (mem_write_addr),
    .o_write_data   (mem_write_data),
    .o_run          (run),
    .o_step         (step),
    .o_pc_clear     (pc_clear),
    .o_state        (o_state)
  );

endmodule

//--- src/fetch_unit.sv
`timescale 1ns/1ps

module fetch_unit #(
  parameter int unsigned MEM_DEPTH = 256  // Bytes of instruction memory
) (
  input  logic                                 i_clock,
  input  logic                                 i_rst_n,
  input  logic                                 i_run,            // Level, fetch every cycle
  input  logic                                 i_step,           // Strobe, fetch once
  input  logic                                 i_pc_clear,       // Strobe, restart at 0
  input  logic                                 i_branch_valid,   // Redirect from a later stage
  input  logic [fetch_pkg::NB_ADDR-1:0]        i_branch_target,
  input  logic [fetch_pkg::NB_INSTRUCTION-1:0] i_read_data,      // Word from memory
  output logic                                 o_read_enable,
  output logic [fetch_pkg::NB_ADDR-1:0]        o_read_addr,
  output logic                                 o_fetch_valid,
  output fetch_pkg::fetch_out_t                o_fetch,
  output logic                                 o_halt            // Halt word delivered
);

  // PC increments wrap inside the memory
  localparam logic [fetch_pkg::NB_ADDR-1:0] PC_MASK = MEM_DEPTH - 1;
  localparam logic [fetch_pkg::NB_ADDR-1:0] PC_INC  = 4;

  logic [fetch_pkg::NB_ADDR-1:0] pc_q;          // Address of the next sequential read
  logic [fetch_pkg::NB_ADDR-1:0] cur_pc;        // PC after a pending clear
  logic                          pending_q;     // A read was issued last cycle
  logic [fetch_pkg::NB_ADDR-1:0] pending_pc_q;  // Its address, pairs with the returning word

  // A clear takes effect in the same cycle it arrives
  always_comb begin
    cur_pc      = i_pc_clear ? '0 : pc_q;
    o_read_addr = i_branch_valid ? i_branch_target : cur_pc;  // Branch wins this cycle
  end

  // A clear also drops a word still in flight from before a load or restart
  assign o_fetch_valid = pending_q && !i_pc_clear;
  assign o_halt        = o_fetch_valid && (i_read_data == fetch_pkg::HALT_INSTR);

  // No read in the cycle the halt word shows up
  assign o_read_enable = (i_run || i_step) && !o_halt;

  assign o_fetch = '{pc: pending_pc_q, instr: i_read_data};

  always_ff @(posedge i_clock) begin
    if (!i_rst_n) begin
      pc_q      <= '0;
      pending_q <= 1'b0;
    end else begin
      pending_q <= o_read_enable;
      if (o_read_enable) begin
        pc_q <= (o_read_addr + PC_INC) & PC_MASK;  // Continue after the word just read
      end else if (i_branch_valid) begin
        pc_q <= i_branch_target;  // Step mode, next step starts here
      end else begin
        pc_q <= cur_pc;  // Holds, or takes the clear
      end
    end
  end

  // Payload only, qualified by pending_q
  always_ff @(posedge i_clock) begin
    if (o_read_enable) begin
      pending_pc_q <= o_read_addr;
    end
  end

endmodule

//--- src/instruction_memory.sv
`timescale 1ns/1ps

module instruction_memory #(
  parameter int unsigned MEM_DEPTH = 256  // Bytes, power of two
) (
  input  logic                                 i_clock,
  input  logic                                 i_write_enable,  // From debug loader
  input  logic [fetch_pkg::NB_ADDR-1:0]        i_write_addr,
  input  logic [fetch_pkg::NB_BYTE-1:0]        i_write_data,
  input  logic                                 i_read_enable,   // From fetch stage
  input  logic [fetch_pkg::NB_ADDR-1:0]        i_read_addr,
  output logic [fetch_pkg::NB_INSTRUCTION-1:0] o_read_data      // One cycle after the request
);

  localparam int NB_IDX = $clog2(MEM_DEPTH);  // Index bits, upper address bits are dropped

  logic [fetch_pkg::NB_BYTE-1:0]        mem [MEM_DEPTH];
  logic [fetch_pkg::NB_INSTRUCTION-1:0] read_q = '0;
  logic [NB_IDX-1:0]                    wr_idx;
  logic [NB_IDX-1:0]                    rd_idx [4];  // Four consecutive bytes, wrapping

  // Power-up contents, the array itself is never reset
  initial begin
    for (int i = 0; i < MEM_DEPTH; i++) begin
      mem[i] = '0;
    end
  end

  assign wr_idx = i_write_addr[NB_IDX-1:0];

  always_comb begin
    for (int b = 0; b < 4; b++) begin
      rd_idx[b] = i_read_addr[NB_IDX-1:0] + NB_IDX'(b);  // Wraps modulo MEM_DEPTH
    end
  end

  always_ff @(posedge i_clock) begin
    if (i_write_enable) begin
      mem[wr_idx] <= i_write_data;  // Single byte per cycle
    end
  end

  // Lowest address lands in the most significant byte
  always_ff @(posedge i_clock) begin
    if (i_read_enable) begin
      read_q <= {mem[rd_idx[0]], mem[rd_idx[1]], mem[rd_idx[2]], mem[rd_idx[3]]};
    end else begin
      read_q <= '0;  // Idle output reads as zero
    end
  end

  assign o_read_data = read_q;

endmodule

//--- tests/fetch_assertions.sv
`timescale 1ns/1ps

module fetch_assertions (
  input logic                          i_clock,
  input logic                          i_rst_n,
  input logic                          i_fetch_valid,
  input fetch_pkg::fetch_out_t         i_fetch,
  input fetch_pkg::dbg_state_e         i_state,
  input logic                          i_branch_valid,
  input logic [fetch_pkg::NB_ADDR-1:0] i_branch_target
);

  fetch_pkg::dbg_state_e prev_state_q;      // State one cycle back
  logic                  unaligned_seen_q;  // Sticky after a misaligned redirect
  logic                  halt_entry;        // First cycle in ST_HALTED

  always_ff @(posedge i_clock) begin
    if (!i_rst_n) begin
      prev_state_q     <= fetch_pkg::ST_IDLE;
      unaligned_seen_q <= 1'b0;
    end else begin
      prev_state_q <= i_state;
      if (i_branch_valid && (i_branch_target[1:0] != 2'b00)) begin
        unaligned_seen_q <= 1'b1;
      end
    end
  end

  assign halt_entry = (i_state == fetch_pkg::ST_HALTED) &&
                      (prev_state_q != fetch_pkg::ST_HALTED);

  // Nothing is fetched while a program is loaded or the core sits idle
  fetch_state_ok: assert property (@(posedge i_clock) disable iff (!i_rst_n)
    i_fetch_valid |-> (i_state != fetch_pkg::ST_LOAD) && (i_state != fetch_pkg::ST_IDLE))
    else $error("fetch pulse in ST_LOAD or ST_IDLE");

  fetch_pc_aligned: assert property (@(posedge i_clock) disable iff (!i_rst_n || unaligned_seen_q)
    i_fetch_valid |-> (i_fetch.pc[1:0] == 2'b00))
    else $error("fetch pc 0x%0h not word aligned", i_fetch.pc);

  // Entry cycle and the one after stay quiet
  fetch_after_halt: assert property (@(posedge i_clock) disable iff (!i_rst_n)
    i_fetch_valid |-> !halt_entry && !$past(halt_entry))
    else $error("fetch pulse right after entering ST_HALTED");

endmodule

//--- tests/fetch_tb.sv
`timescale 1ns/1ps

module fetch_tb;

  localparam int          MEM_DEPTH      = 64;  // Small memory keeps a full load short
  localparam int          TIMEOUT_CYCLES = 200;
  localparam logic [31:0] HALT_WORD      = 32'hFFFF_FFFF;

  typedef struct packed {
    logic [31:0] at_cycle;  // Cycle the pulse has to show up in
    logic [31:0] pc;
  } fetch_expect_t;

  logic                  i_clock         = 1'b0;
  logic                  i_rst_n         = 1'b0;
  logic                  i_cmd_valid     = 1'b0;
  fetch_pkg::dbg_cmd_e   i_cmd           = fetch_pkg::CMD_NOP;
  logic                  i_byte_valid    = 1'b0;
  logic [7:0]            i_byte          = '0;
  logic                  i_branch_valid  = 1'b0;
  logic [31:0]           i_branch_target = '0;
  logic                  o_fetch_valid;
  fetch_pkg::fetch_out_t o_fetch;
  fetch_pkg::dbg_state_e o_state;

  logic [7:0]    mem_model [MEM_DEPTH];  // Expected DUT memory contents
  logic [7:0]    image [MEM_DEPTH];      // Next program to load
  fetch_expect_t expected_q [$];
  logic [31:0]   fetch_order [$];        // PCs in the order they arrived
  logic [31:0]   cycle = '0;
  logic [31:0]   cmd_cycle;
  logic [31:0]   branch_cycle;
  logic          halt_pending = 1'b0;    // Halt word seen, state checked next cycle
  integer        seed;

  fetch_top #(.MEM_DEPTH(MEM_DEPTH)) i_dut (
    .i_clock(i_clock), .i_rst_n(i_rst_n),
    .i_cmd_valid(i_cmd_valid), .i_cmd(i_cmd),
    .i_byte_valid(i_byte_valid), .i_byte(i_byte),
    .i_branch_valid(i_branch_valid), .i_branch_target(i_branch_target),
    .o_fetch_valid(o_fetch_valid), .o_fetch(o_fetch), .o_state(o_state)
  );

  bind fetch_top fetch_assertions u_fetch_assertions (
    .i_clock(i_clock), .i_rst_n(i_rst_n), .i_fetch_valid(o_fetch_valid),
    .i_fetch(o_fetch), .i_state(o_state),
    .i_branch_valid(i_branch_valid), .i_branch_target(i_branch_target)
  );

  always #50 i_clock = ~i_clock;  // 100 ns period

  always @(posedge i_clock) begin
    cycle <= cycle + 1;
  end

  // Big-endian word at addr, bytes wrap around the memory
  function automatic logic [31:0] expected_word(input logic [31:0] addr);
    logic [31:0] word;
    word = '0;
    for (int b = 0; b < 4; b++) begin
      word = {word[23:0], mem_model[(addr + b) % MEM_DEPTH]};
    end
    return word;
  endfunction

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("SOME TESTS FAILED");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [63:0] actual,
                             input logic [63:0] expected);
    if (actual !== expected) begin
      abort_run($sformatf("error: %s is 0x%0h, expected 0x%0h", name, actual, expected));
    end
  endtask

  // Strobe tasks start and end on a falling edge
  task automatic send_cmd(input fetch_pkg::dbg_cmd_e cmd);
    i_cmd_valid = 1'b1;
    i_cmd       = cmd;
    cmd_cycle   = cycle;
    @(negedge i_clock);
    i_cmd_valid = 1'b0;
    i_cmd       = fetch_pkg::CMD_NOP;
  endtask

  task automatic send_byte(input logic [7:0] value);
    i_byte_valid = 1'b1;
    i_byte       = value;
    @(negedge i_clock);
    i_byte_valid = 1'b0;
  endtask

  task automatic send_branch(input logic [31:0] target);
    i_branch_valid  = 1'b1;
    i_branch_target = target;
    branch_cycle    = cycle;
    @(negedge i_clock);
    i_branch_valid  = 1'b0;
  endtask

  task automatic expect_fetch(input logic [31:0] at_cycle, input logic [31:0] pc);
    expected_q.push_back('{at_cycle: at_cycle, pc: pc});
  endtask

  task automatic wait_state(input fetch_pkg::dbg_state_e want);
    int n;
    n = 0;
    while (o_state != want) begin
      @(negedge i_clock);
      n++;
      if (n > TIMEOUT_CYCLES) abort_run($sformatf("timed out waiting for %s", want.name()));
    end
  endtask

  task automatic wait_fetches();
    int n;
    n = 0;
    while (expected_q.size() != 0) begin
      @(negedge i_clock);
      n++;
      if (n > TIMEOUT_CYCLES) abort_run("timed out waiting for expected fetches");
    end
  endtask

  task automatic fill_random(input int n_bytes);
    for (int i = 0; i < n_bytes; i++) begin
      image[i] = 8'($random(seed));
      if ((i % 4 == 0) && (image[i] == 8'hff)) image[i] = 8'h5a;  // No stray halt words
    end
  endtask

  task automatic place_halt(input int addr);
    for (int i = 0; i < 4; i++) image[addr + i] = HALT_WORD[31-8*i -: 8];
  endtask

  task automatic load_image(input int n_bytes, input bit poke_cmds);
    int i;
    send_cmd(fetch_pkg::CMD_LOAD);
    check_value("o_state", o_state, fetch_pkg::ST_LOAD);
    for (i = 0; i < n_bytes; i++) begin
      if (poke_cmds && (i == 6)) begin
        send_cmd(fetch_pkg::CMD_RUN);   // All ignored, pointer keeps counting
        send_cmd(fetch_pkg::CMD_STEP);
        send_cmd(fetch_pkg::CMD_LOAD);
        check_value("o_state", o_state, fetch_pkg::ST_LOAD);
      end
      send_byte(image[i]);
      mem_model[i] = image[i];
      if (i < n_bytes - 1) check_value("o_state", o_state, fetch_pkg::ST_LOAD);
    end
    check_value("o_state", o_state, fetch_pkg::ST_IDLE);  // Cycle after the last byte
  endtask

  task automatic step_once(input logic [31:0] pc);
    send_cmd(fetch_pkg::CMD_STEP);
    expect_fetch(cmd_cycle + 2, pc);
    wait_fetches();
  endtask

  // Compare every fetch pulse against the expected queue
  always @(posedge i_clock) begin
    fetch_expect_t exp_fetch;
    if (halt_pending) begin
      check_value("o_state", o_state, fetch_pkg::ST_HALTED);
      halt_pending = 1'b0;
    end
    if (i_rst_n && o_fetch_valid) begin
      if (expected_q.size() == 0) abort_run("a fetch pulse arrived when none was expected");
      exp_fetch = expected_q.pop_front();
      check_value("fetch cycle", cycle, exp_fetch.at_cycle);
      check_value("o_fetch.pc", o_fetch.pc, exp_fetch.pc);
      check_value("o_fetch.instr", o_fetch.instr, expected_word(exp_fetch.pc));
      fetch_order.push_back(o_fetch.pc);
      if (expected_word(exp_fetch.pc) == HALT_WORD) halt_pending = 1'b1;
    end
  end

  initial begin
    int          gap;
    logic [31:0] target;
    seed = 32'hb9ea_f348;
    for (int i = 0; i < MEM_DEPTH; i++) mem_model[i] = '0;  // Power-up contents
    repeat (10) @(negedge i_clock);
    i_rst_n = 1'b1;
    @(negedge i_clock);
    check_value("o_state", o_state, fetch_pkg::ST_IDLE);
    check_value("o_fetch_valid", o_fetch_valid, 1'b0);
    repeat (3) @(negedge i_clock);
    // Load 12 words plus halt, then free run
    fill_random(48);
    place_halt(48);
    load_image(52, 1'b0);
    send_cmd(fetch_pkg::CMD_RUN);
    for (int k = 0; k <= 12; k++) expect_fetch(cmd_cycle + 2 + k, 4 * k);
    repeat (3) @(negedge i_clock);
    send_cmd(fetch_pkg::CMD_RUN);  // Already running
    send_byte(8'hff);              // Not loading
    wait_state(fetch_pkg::ST_HALTED);
    wait_fetches();
    repeat (2) @(negedge i_clock);
    // Step through the whole program
    send_cmd(fetch_pkg::CMD_STEP);
    check_value("o_state", o_state, fetch_pkg::ST_STEP);
    repeat (3) @(negedge i_clock);
    for (int k = 0; k <= 12; k++) step_once(4 * k);
    wait_state(fetch_pkg::ST_HALTED);
    repeat (2) @(negedge i_clock);
    // Redirect in the middle of a run
    gap    = 1 + ({$random(seed)} % 5);
    target = 4 * ({$random(seed)} % 12);
    if (target == 4 * gap) begin
      target = target + 8;  // Sequential PC would hide the redirect
    end
    send_cmd(fetch_pkg::CMD_RUN);
    for (int k = 0; k < gap; k++) expect_fetch(cmd_cycle + 2 + k, 4 * k);
    repeat (gap) @(negedge i_clock);
    send_branch(target);
    for (int pc = target; pc <= 48; pc += 4) begin
      expect_fetch(branch_cycle + 1 + (pc - target) / 4, pc);
    end
    wait_state(fetch_pkg::ST_HALTED);
    wait_fetches();
    repeat (2) @(negedge i_clock);
    // Redirect between steps moves only the next step
    send_cmd(fetch_pkg::CMD_STEP);
    step_once(0);
    step_once(4);
    target = 4 * ({$random(seed)} % 12);
    if (target == 8) begin
      target = 32;  // Next step would land on 8 anyway
    end
    send_branch(target);
    for (int pc = target; pc <= 48; pc += 4) step_once(pc);
    wait_state(fetch_pkg::ST_HALTED);
    repeat (2) @(negedge i_clock);
    // Full memory load with no halt word, later bytes ignored
    fill_random(MEM_DEPTH);
    load_image(MEM_DEPTH, 1'b0);
    repeat (4) send_byte(8'hff);
    check_value("o_state", o_state, fetch_pkg::ST_IDLE);
    send_cmd(fetch_pkg::CMD_STEP);
    for (int k = 0; k < MEM_DEPTH / 4; k++) step_once(4 * k);
    // Halt bytes at 1..4 must not end the load
    fill_random(40);
    for (int i = 1; i <= 4; i++) image[i] = 8'hff;
    if (image[5] == 8'hff) image[5] = 8'h00;
    place_halt(40);
    load_image(44, 1'b1);
    send_byte(8'h3c);
    send_cmd(fetch_pkg::CMD_RUN);
    for (int k = 0; k <= 10; k++) expect_fetch(cmd_cycle + 2 + k, 4 * k);
    wait_state(fetch_pkg::ST_HALTED);
    wait_fetches();
    repeat (3) @(negedge i_clock);
    $display("%0d fetches checked in order", fetch_order.size());
    $display("ALL TESTS PASSED");
    $finish;
  end

endmodule
